//--- dv/spi_reg_bridge_asserts.sv
`timescale 1ns/10ps

// protocol checks bound into the bridge top
module spi_reg_bridge_asserts import spi_link_pkg::*, reg_cmd_pkg::*; (
    input logic           clk,
    input logic           rst,
    input logic           sclk,
    input logic           miso,
    input logic           byte_done,
    input logic           frame_active,
    input logic           cmd_valid,
    input logic           exe_valid,
    input spi_bit_state_t bit_state,    // bit engine state
    input frame_state_t   fstate        // decoder state
);

    int assert_fails = 0;

    //////////////////////////////////////////////////
    // pipeline strobes
    //////////////////////////////////////////////////

    a_byte_done_pulse: assert property (@(posedge clk) disable iff (rst)
        byte_done |=> !byte_done)
        else begin
            assert_fails++;
            $error("byte_done stayed high for more than one cycle");
        end

    a_cmd_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |=> !cmd_valid)
        else begin
            assert_fails++;
            $error("cmd_valid stayed high for more than one cycle");
        end

    a_exe_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        exe_valid |=> !exe_valid)
        else begin
            assert_fails++;
            $error("exe_valid stayed high for more than one cycle");
        end

    // execute stage is exactly one cycle behind the decoder
    a_exe_after_cmd: assert property (@(posedge clk) disable iff (rst)
        (cmd_valid |=> exe_valid) and (exe_valid |-> $past(cmd_valid)))
        else begin
            assert_fails++;
            $error("exe_valid not one cycle after cmd_valid");
        end

    //////////////////////////////////////////////////
    // SPI side
    //////////////////////////////////////////////////

    // miso moves only right after the engine sees the leading sclk edge
    a_miso_on_rise: assert property (@(posedge clk) disable iff (rst)
        $changed(miso) |-> $past(bit_state == wait_sclk_high && sclk))
        else begin
            assert_fails++;
            $error("miso changed outside an sclk rise");
        end

    a_hdr_when_idle: assert property (@(posedge clk) disable iff (rst)
        !frame_active |=> fstate == expect_header)   // decoder catches up one cycle later
        else begin
            assert_fails++;
            $error("decoder not back to expect_header with cs high");
        end

endmodule

//--- dv/spi_reg_bridge_tb.sv
`timescale 1ns/10ps
`include "spi_bridge_consts.svh"

module spi_reg_bridge_tb import reg_cmd_pkg::*; ();

    localparam int n_frames    = 80;
    localparam int cycle_limit = n_frames * (2 * `SPI_BYTE_W * 8 + 10) + 2000;

    logic clk;
    logic rst;
    logic cs;
    logic sclk;
    logic mosi;
    logic miso;

    // reference model of the register file and counters
    logic [7:0]  model_regs [`REG_COUNT];
    logic [3:0]  model_err;
    logic [3:0]  model_cmd;
    logic [7:0]  model_reply;       // what the next frame shifts out
    cmd_opcode_t model_last_op;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          tests;
    int          cycles = 0;

    spi_reg_bridge i_spi_reg_bridge (
        .clk  (clk),
        .rst  (rst),
        .cs   (cs),
        .sclk (sclk),
        .mosi (mosi),
        .miso (miso)
    );

    bind spi_reg_bridge spi_reg_bridge_asserts i_spi_reg_bridge_asserts (
        .clk          (clk),
        .rst          (rst),
        .sclk         (sclk),
        .miso         (miso),
        .byte_done    (byte_done),
        .frame_active (frame_active),
        .cmd_valid    (cmd_valid),
        .exe_valid    (exe_valid),
        .bit_state    (i_spi_slave_driver.state),
        .fstate       (i_cmd_decode.fstate)
    );

    always #50 clk = ~clk;          // 100 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, tests did not complete", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [7:0] lfsr_bits(input int n);
        logic [7:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[6:0], fb};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_reply(input string what, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %02h actual %02h", $time, what, exp, act);
        end
    endtask

    task automatic check_opcode_reply(input cmd_opcode_t op, input logic [7:0] exp,
                                      input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: miso reply to %s expected %02h actual %02h",
                     $time, op.name(), exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // SPI master and model
    //////////////////////////////////////////////////

    // mode 1 master setting mosi with the rise and taking miso at the end of the high phase
    task automatic spi_frame(input logic [7:0] hdr, input logic [7:0] opnd, input int nbits,
                             output logic [15:0] rx);
        logic [15:0] tx;
        tx = {hdr, opnd};
        rx = '0;
        @(negedge clk);
        cs = 1'b0;
        repeat (4) @(negedge clk);
        for (int i = 0; i < nbits; i++) begin
            sclk = 1'b1;
            mosi = tx[15 - i];
            repeat (4) @(negedge clk);
            rx   = {rx[14:0], miso};
            sclk = 1'b0;
            repeat (4) @(negedge clk);
        end
        cs = 1'b1;
        rx = rx << (16 - nbits);    // first received bit ends up in bit 15
        repeat (10) @(negedge clk);
    endtask

    task automatic predict(input cmd_opcode_t op, input logic bad, input logic [2:0] addr,
                           input logic [7:0] opnd);
        logic [7:0] cur;
        cur           = model_regs[addr];
        model_last_op = op;
        if (bad || op inside {OP_RSV5, OP_RSV6, OP_RSV7}) begin
            model_reply = `ERR_REPLY;
            model_err   = model_err + 4'd1;
        end else begin
            case (op)
                OP_READ:  model_reply = cur;
                OP_WRITE: model_reply = opnd;
                OP_ADD:   model_reply = cur + opnd;             // mod 256
                OP_XOR:   model_reply = cur ^ opnd;
                default:  model_reply = {model_err, model_cmd}; // STAT counts exclude itself
            endcase
            if (op inside {OP_WRITE, OP_ADD, OP_XOR}) begin
                model_regs[addr] = model_reply;
            end
        end
        model_cmd = model_cmd + 4'd1;
    endtask

    // one frame whose reply is checked against the previous completed command
    task automatic run_cmd(input cmd_opcode_t op, input logic [1:0] rsv, input logic [2:0] addr,
                           input logic [7:0] opnd, input int nbits);
        logic [15:0] rx;
        spi_frame({op, rsv, addr}, opnd, nbits, rx);
        if (nbits >= 8) begin
            check_opcode_reply(model_last_op, model_reply, rx[15:8]);
        end
        if (nbits == 16) begin
            check_reply("miso byte 1", model_reply, rx[7:0]);
            predict(op, rsv != 2'b00, addr, opnd);
        end
    endtask

    task automatic end_test(input string name, input int err_at_start);
        tests++;
        $display("test %s: %s, %0d errors", name,
                 (errors == err_at_start) ? "ok" : "failed", errors - err_at_start);
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_values();
        int e0;
        e0 = errors;
        for (int a = 0; a < `REG_COUNT; a++) begin
            run_cmd(OP_READ, 2'b00, a[2:0], lfsr_bits(8), 16);  // operand ignored
        end
        end_test("reset values", e0);
    endtask

    task automatic test_write_read();
        int e0;
        e0 = errors;
        run_cmd(OP_WRITE, 2'b00, 3'd0, 8'h11, 16);
        run_cmd(OP_WRITE, 2'b00, 3'd3, 8'h3C, 16);
        run_cmd(OP_WRITE, 2'b00, 3'd6, 8'hA5, 16);
        run_cmd(OP_WRITE, 2'b00, 3'd7, 8'h7E, 16);
        run_cmd(OP_READ,  2'b00, 3'd0, 8'h00, 16);
        run_cmd(OP_READ,  2'b00, 3'd3, 8'h00, 16);
        run_cmd(OP_READ,  2'b00, 3'd6, 8'h00, 16);
        run_cmd(OP_READ,  2'b00, 3'd7, 8'h00, 16);
        end_test("write and read back", e0);
    endtask

    task automatic test_arith();
        int e0;
        e0 = errors;
        run_cmd(OP_WRITE, 2'b00, 3'd2, 8'hF0, 16);
        run_cmd(OP_ADD,   2'b00, 3'd2, 8'h20, 16);  // carry out dropped
        run_cmd(OP_READ,  2'b00, 3'd2, 8'h00, 16);
        run_cmd(OP_WRITE, 2'b00, 3'd5, 8'h5A, 16);
        run_cmd(OP_XOR,   2'b00, 3'd5, 8'hA5, 16);
        run_cmd(OP_XOR,   2'b00, 3'd5, 8'h0F, 16);
        run_cmd(OP_READ,  2'b00, 3'd5, 8'h00, 16);
        end_test("arithmetic", e0);
    endtask

    task automatic test_errors_stat();
        int e0;
        e0 = errors;
        run_cmd(OP_RSV5,  2'b00, 3'd1, 8'h55, 16);
        run_cmd(OP_RSV6,  2'b00, 3'd2, 8'h66, 16);
        run_cmd(OP_RSV7,  2'b00, 3'd5, 8'h77, 16);
        run_cmd(OP_WRITE, 2'b01, 3'd2, 8'h99, 16);  // reserved header bit 3
        run_cmd(OP_ADD,   2'b10, 3'd5, 8'h01, 16);  // reserved header bit 4
        run_cmd(OP_READ,  2'b00, 3'd2, 8'h00, 16);
        run_cmd(OP_READ,  2'b00, 3'd5, 8'h00, 16);
        run_cmd(OP_STAT,  2'b00, 3'd0, 8'h00, 16);
        run_cmd(OP_STAT,  2'b00, 3'd0, 8'h00, 16);  // now counts the first STAT
        end_test("errors and status", e0);
    endtask

    task automatic test_aborts();
        int e0;
        e0 = errors;
        run_cmd(OP_WRITE, 2'b00, 3'd4, 8'h3C, 8);   // header only
        run_cmd(OP_WRITE, 2'b00, 3'd4, 8'hC3, 12);  // cut inside the operand
        run_cmd(OP_READ,  2'b00, 3'd4, 8'h00, 16);
        run_cmd(OP_XOR,   2'b00, 3'd4, 8'hFF, 8);
        run_cmd(OP_READ,  2'b00, 3'd4, 8'h00, 16);
        end_test("aborted frames", e0);
    endtask

    task automatic test_random();
        int         e0;
        logic [7:0] r_op;
        logic [7:0] r_addr;
        logic [7:0] r_opnd;
        e0 = errors;
        for (int n = 0; n < 40; n++) begin
            r_op   = lfsr_bits(2);                  // READ, WRITE, ADD or XOR
            r_addr = lfsr_bits(3);
            r_opnd = lfsr_bits(8);
            run_cmd(cmd_opcode_t'({1'b0, r_op[1:0]}), 2'b00, r_addr[2:0], r_opnd, 16);
        end
        run_cmd(OP_READ, 2'b00, 3'd0, 8'h00, 16);   // collects the last reply
        end_test("random commands", e0);
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        cs            = 1'b1;
        sclk          = 1'b0;
        mosi          = 1'b0;
        lfsr          = 32'h79de;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        model_err     = '0;
        model_cmd     = '0;
        model_reply   = '0;
        model_last_op = OP_READ;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        test_reset_values();
        test_write_read();
        test_arith();
        test_errors_stat();
        test_aborts();
        test_random();
        errors = errors + i_spi_reg_bridge.i_spi_reg_bridge_asserts.assert_fails;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- hw/cmd_decode.sv
`timescale 1ns/10ps
`include "spi_bridge_consts.svh"

// turns the two bytes of one cs frame into a command
module cmd_decode import reg_cmd_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   byte_done,
    input  logic [`SPI_BYTE_W-1:0] rx_byte,
    input  logic                   frame_active,
    output logic                   cmd_valid,
    output cmd_opcode_t            cmd_op,
    output logic [`REG_ADDR_W-1:0] cmd_addr,
    output logic [`SPI_BYTE_W-1:0] cmd_operand,
    output logic                   cmd_bad      // reserved header bits set
);

    frame_state_t           fstate;
    logic [`SPI_BYTE_W-1:0] hdr;                // header held until the operand arrives

    always_ff @(posedge clk) begin
        if (rst) begin
            fstate    <= expect_header;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (!frame_active) begin
                fstate <= expect_header;            // short frames die here
            end else begin
                case (fstate)
                    expect_header: begin
                        if (byte_done) begin
                            fstate <= expect_operand;
                        end
                    end
                    expect_operand: begin
                        if (byte_done) begin
                            cmd_valid <= 1'b1;
                            fstate    <= frame_done;
                        end
                    end
                    frame_done: ;                   // ignore trailing bytes
                    default: fstate <= expect_header;
                endcase
            end
        end
    end

    // header layout is op[7:5] reserved[4:3] addr[2:0]
    always_ff @(posedge clk) begin
        if (byte_done && fstate == expect_header) begin
            hdr <= rx_byte;
        end
        if (byte_done && fstate == expect_operand) begin
            cmd_op      <= cmd_opcode_t'(hdr[7:5]);
            cmd_addr    <= hdr[`REG_ADDR_W-1:0];
            cmd_bad     <= |hdr[4:3];
            cmd_operand <= rx_byte;
        end
    end

endmodule

//--- hw/reg_cmd_pkg.sv
// command level types for the register bridge
package reg_cmd_pkg;

    //////////////////////////////////////////////////
    // opcodes in header bits 7..5
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_READ  = 3'd0,    // reply with register
        OP_WRITE = 3'd1,    // store operand, echo it
        OP_ADD   = 3'd2,    // reg + operand, mod 256
        OP_XOR   = 3'd3,    // reg ^ operand
        OP_STAT  = 3'd4,    // error / command counters
        OP_RSV5  = 3'd5,    // reserved with error reply
        OP_RSV6  = 3'd6,
        OP_RSV7  = 3'd7
    } cmd_opcode_t;

    //////////////////////////////////////////////////
    // frame decoder states
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        expect_header  = 2'd0,  // first byte of the frame
        expect_operand = 2'd1,  // second byte issues the command
        frame_done     = 2'd2   // extra bytes dropped until cs goes high
    } frame_state_t;

endpackage

//--- hw/reg_execute.sv
`timescale 1ns/10ps
`include "spi_bridge_consts.svh"

// eight byte register file, one command per cmd_valid
module reg_execute import reg_cmd_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_valid,
    input  cmd_opcode_t            cmd_op,
    input  logic [`REG_ADDR_W-1:0] cmd_addr,
    input  logic [`SPI_BYTE_W-1:0] cmd_operand,
    input  logic                   cmd_bad,
    output logic                   exe_valid,
    output cmd_opcode_t            exe_op,
    output logic [`SPI_BYTE_W-1:0] exe_value,
    output logic                   exe_err
);

    logic [`SPI_BYTE_W-1:0] regs [`REG_COUNT];
    logic [`SPI_BYTE_W-1:0] cur;                // addressed register
    logic [`SPI_BYTE_W-1:0] result;
    logic                   wr_en;
    logic                   err;

    assign cur = regs[cmd_addr];

    //////////////////////////////////////////////////
    // opcode decode
    //////////////////////////////////////////////////

    always_comb begin
        result = cur;                           // READ and STAT leave it as is
        wr_en  = 1'b0;
        err    = cmd_bad;
        case (cmd_op)
            OP_READ:  ;
            OP_WRITE: begin
                result = cmd_operand;
                wr_en  = 1'b1;
            end
            OP_ADD: begin
                result = cur + cmd_operand;     // wraps at 256
                wr_en  = 1'b1;
            end
            OP_XOR: begin
                result = cur ^ cmd_operand;
                wr_en  = 1'b1;
            end
            OP_STAT:  ;                         // reply built downstream from counters
            default:  err = 1'b1;               // reserved opcodes
        endcase
        if (err) begin
            wr_en = 1'b0;                       // a bad command never touches the file
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_valid <= 1'b0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            exe_valid <= cmd_valid;
            if (cmd_valid && wr_en) begin
                regs[cmd_addr] <= result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            exe_op    <= cmd_op;
            exe_value <= result;
            exe_err   <= err;
        end
    end

endmodule

//--- hw/resp_result.sv
`timescale 1ns/10ps
`include "spi_bridge_consts.svh"

// counters and the reply byte held for the next frame
module resp_result import reg_cmd_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   exe_valid,
    input  cmd_opcode_t            exe_op,
    input  logic [`SPI_BYTE_W-1:0] exe_value,
    input  logic                   exe_err,
    output logic [`SPI_BYTE_W-1:0] tx_byte
);

    logic [3:0] cmd_cnt;                        // every executed command including errors
    logic [3:0] err_cnt;

    //////////////////////////////////////////////////
    // reply select and counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_byte <= '0;                      // first frame after reset replies 00
            cmd_cnt <= '0;
            err_cnt <= '0;
        end else if (exe_valid) begin
            cmd_cnt <= cmd_cnt + 1'b1;          // wraps at 16
            if (exe_err) begin
                tx_byte <= `ERR_REPLY;
                err_cnt <= err_cnt + 1'b1;
            end else if (exe_op == OP_STAT) begin
                // old counts so STAT sees itself only in the next STAT
                tx_byte <= {err_cnt, cmd_cnt};
            end else begin
                tx_byte <= exe_value;           // data opcodes echo the result
            end
        end
    end

endmodule

//--- hw/spi_bridge_consts.svh
`ifndef SPI_BRIDGE_CONSTS_SVH
`define SPI_BRIDGE_CONSTS_SVH

// width of one SPI transfer unit
`define SPI_BYTE_W 8

// register file geometry
`define REG_COUNT  8
`define REG_ADDR_W 3

// reply for reserved opcodes and malformed headers
`define ERR_REPLY  8'hEE

`endif

//--- hw/spi_link_pkg.sv
// types for the SPI slave bit engine
package spi_link_pkg;

    //////////////////////////////////////////////////
    // bit engine states
    //////////////////////////////////////////////////

    // idle waits with cs high for a frame to open
    // wait_sclk_high waits for the leading sclk edge and updates miso on it
    // wait_sclk_low waits for the trailing sclk edge and samples mosi on it
    typedef enum logic [1:0] {
        idle           = 2'd0,
        wait_sclk_high = 2'd1,
        wait_sclk_low  = 2'd2
    } spi_bit_state_t;

    // encoding 3 is unused and falls back to idle

endpackage

//--- hw/spi_reg_bridge.sv
`timescale 1ns/10ps
`include "spi_bridge_consts.svh"

// SPI register bridge top
module spi_reg_bridge import reg_cmd_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);

    // bit engine <-> decoder / result
    logic [`SPI_BYTE_W-1:0] rx_byte;
    logic                   byte_done;
    logic                   frame_active;
    logic [`SPI_BYTE_W-1:0] tx_byte;

    // decoder -> execute
    logic                   cmd_valid;
    cmd_opcode_t            cmd_op;
    logic [`REG_ADDR_W-1:0] cmd_addr;
    logic [`SPI_BYTE_W-1:0] cmd_operand;
    logic                   cmd_bad;

    // execute -> result
    logic                   exe_valid;
    cmd_opcode_t            exe_op;
    logic [`SPI_BYTE_W-1:0] exe_value;
    logic                   exe_err;

    spi_slave_driver #(
        .data_width (`SPI_BYTE_W)
    ) i_spi_slave_driver (
        .clk          (clk),
        .rst          (rst),
        .cs           (cs),
        .sclk         (sclk),
        .mosi         (mosi),
        .miso         (miso),
        .tx_byte      (tx_byte),
        .rx_byte      (rx_byte),
        .byte_done    (byte_done),
        .frame_active (frame_active)
    );

    cmd_decode i_cmd_decode (
        .clk          (clk),
        .rst          (rst),
        .byte_done    (byte_done),
        .rx_byte      (rx_byte),
        .frame_active (frame_active),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_operand  (cmd_operand),
        .cmd_bad      (cmd_bad)
    );

    reg_execute i_reg_execute (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_operand (cmd_operand),
        .cmd_bad     (cmd_bad),
        .exe_valid   (exe_valid),
        .exe_op      (exe_op),
        .exe_value   (exe_value),
        .exe_err     (exe_err)
    );

    resp_result i_resp_result (
        .clk       (clk),
        .rst       (rst),
        .exe_valid (exe_valid),
        .exe_op    (exe_op),
        .exe_value (exe_value),
        .exe_err   (exe_err),
        .tx_byte   (tx_byte)
    );

endmodule

//--- hw/spi_slave_driver.sv
`timescale 1ns/10ps
`include "spi_bridge_consts.svh"

// SPI mode 1 slave with miso changed on sclk rise and mosi sampled on sclk fall
module spi_slave_driver import spi_link_pkg::*; #(
    parameter int data_width = `SPI_BYTE_W
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cs,           // active low
    input  logic                  sclk,
    input  logic                  mosi,
    output logic                  miso,
    input  logic [data_width-1:0] tx_byte,      // reply sampled every cycle
    output logic [data_width-1:0] rx_byte,
    output logic                  byte_done,    // one cycle pulse with rx_byte
    output logic                  frame_active  // registered !cs
);

    localparam int cnt_w = $clog2(data_width + 1);

    spi_bit_state_t        state;
    logic                  sel;                 // which buffer is shifting
    logic [data_width-1:0] shreg [2];           // ping-pong shift buffers
    logic [cnt_w-1:0]      bit_cnt;             // bit in flight 1..n and 0 before the first
    logic                  work;
    logic                  load;
    logic                  sclk_fall;
    logic                  byte_wrap;
    logic [data_width-1:0] shifted;

    assign work      = sel;
    assign load      = ~sel;
    assign sclk_fall = (state == wait_sclk_low) && !sclk;
    assign byte_wrap = (bit_cnt == cnt_w'(data_width));    // last bit of a byte reached
    assign shifted   = {shreg[work][data_width-2:0], mosi};

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= idle;
            sel          <= 1'b0;
            bit_cnt      <= '0;
            miso         <= 1'b0;
            byte_done    <= 1'b0;
            frame_active <= 1'b0;
        end else begin
            byte_done    <= 1'b0;
            frame_active <= !cs;
            case (state)
                idle: begin
                    if (!cs) begin                          // frame opens
                        bit_cnt <= '0;
                        sel     <= ~sel;                    // preloaded reply starts shifting
                        state   <= wait_sclk_high;
                    end
                end
                wait_sclk_high: begin
                    if (sclk) begin
                        state <= wait_sclk_low;
                        if (byte_wrap) begin
                            // next byte replies from the freshly loaded buffer
                            miso    <= shreg[load][data_width-1];
                            sel     <= ~sel;
                            bit_cnt <= cnt_w'(1);
                        end else begin
                            miso    <= shreg[work][data_width-1];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (cs) begin
                        state <= idle;                      // frame closed between bits
                    end
                end
                wait_sclk_low: begin
                    if (!sclk) begin
                        byte_done <= byte_wrap;             // eighth bit now in
                        state     <= wait_sclk_high;
                    end else if (cs) begin
                        state <= idle;                      // abort with sclk still high
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // data path
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        shreg[load] <= tx_byte;                             // keep the spare buffer current
        if (sclk_fall) begin
            shreg[work] <= shifted;                         // msb already on miso
            if (byte_wrap) begin
                rx_byte <= shifted;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module spi_reg_bridge_tb -f sim.f

out=$(./obj_dir/Vspi_reg_bridge_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF '** PASS **'

//--- sim.f
+incdir+hw
hw/spi_link_pkg.sv
hw/reg_cmd_pkg.sv
hw/spi_slave_driver.sv
hw/cmd_decode.sv
hw/reg_execute.sv
hw/resp_result.sv
hw/spi_reg_bridge.sv
dv/spi_reg_bridge_asserts.sv
dv/spi_reg_bridge_tb.sv
